// ==== cid_fifo.sv ====
// ---------------------------------------------------------
// cid fifo: circular buffer with valid, pop and occupancy
// ---------------------------------------------------------

`timescale 1ns/1ns

module cid_fifo
(
   input  logic                              clk,
   input  logic                              reset,
   input  logic                              push,
   input  logic [unmap_pkg::cid_width-1:0]   din,
   input  logic                              pop,
   output logic                              valid,
   output logic [unmap_pkg::cid_width-1:0]   dout,
   output logic [unmap_pkg::used_width-1:0]  used
);
   import unmap_pkg::*;

   logic [cid_width-1:0]  mem [fifo_depth];
   logic [used_width-2:0] wr_ptr;
   logic [used_width-2:0] rd_ptr;

   // storage
   always_ff @(posedge clk)
   begin
      if (push)
         mem[wr_ptr] <= din;
   end

   // pointers wrap naturally, depth is a power of two
   always_ff @(posedge clk or posedge reset)
   begin
      if (reset)
      begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         used   <= '0;
      end
      else
      begin
         if (push)
            wr_ptr <= wr_ptr + 1'b1;
         if (pop)
            rd_ptr <= rd_ptr + 1'b1;
         case ({push, pop})
            2'b10:   used <= used + 1'b1;
            2'b01:   used <= used - 1'b1;
            default: used <= used;
         endcase
      end
   end

   assign valid = (used != '0);
   assign dout  = mem[rd_ptr];

   a_no_overflow: assert property (@(posedge clk) disable iff (reset)
      push |-> (used != used_width'(fifo_depth)));

   a_no_underflow: assert property (@(posedge clk) disable iff (reset)
      pop |-> valid);

endmodule

// ==== run_sim.sh ====
#!/bin/sh
# build and run the unmap coalescer testbench with Verilator
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -f vlog.f --top-module tb_unmap -o sim_unmap \
   > build.log 2>&1 || { echo "build failed, see build.log"; exit 1; }
./obj_dir/sim_unmap > sim.log 2>&1 || { echo "simulation error, see sim.log"; exit 1; }
cat sim.log
grep -q "TEST FAILED" sim.log && { echo "failures found in sim.log"; exit 1; }
grep -q "TEST PASSED" sim.log || { echo "no result in sim.log"; exit 1; }
exit 0

// ==== tb_unmap_model.svh ====
// ---------------------------------------------------------
// reference model for the unmap coalescer testbench
// builds the expected event and buffer free lists
// ---------------------------------------------------------

// cids are split into batches of up to rc+1 in push order
// every batch ends in ev_write_last, then its buffer is freed,
// then one ev_cpl per cid carries the batch status
function automatic void build_expected(input logic [15:0] cids[$], input int rc);
   int   off;
   int   batch;
   int   first;
   logic is_last;
   off   = 0;
   batch = 0;
   first = 0;
   for (int i = 0; i < cids.size(); i++)
   begin
      is_last = (off == rc) || (off == max_ranges) || (i == cids.size() - 1);
      exp_cid.push_back(cids[i]);
      exp_ev.push_back(is_last ? 4'(ev_write_last) : 4'(ev_write));
      exp_wb.push_back(wb_table[batch]);
      exp_st.push_back('0);
      exp_off.push_back(8'(off));
      exp_batch.push_back(batch);
      if (is_last)
      begin
         exp_free.push_back(wb_table[batch]);
         for (int j = first; j <= i; j++)
         begin
            exp_cid.push_back(cids[j]);
            exp_ev.push_back(4'(ev_cpl));
            exp_wb.push_back(wb_table[batch]);
            exp_st.push_back(st_table[batch]);
            exp_off.push_back('0);
            exp_batch.push_back(batch);
         end
         batch = batch + 1;
         first = i + 1;
         off   = 0;
      end
      else
         off = off + 1;
   end
endfunction

// ==== tb_unmap.sv ====
// ---------------------------------------------------------
// testbench for the unmap coalescer
// lfsr stimulus, ack responders, event monitor, summary
// ---------------------------------------------------------

`timescale 1ns/1ns

module tb_unmap;
   import unmap_pkg::*;

   localparam int num_tests   = 6;
   localparam int t1_short    = 10;
   localparam int t1_max      = 4095;
   localparam int t2_lim      = 20;
   localparam int t2_long     = 30;
   localparam int cycle_limit = 400 * num_tests + t1_short + t1_max + t2_lim + t2_long;

   logic                    clk;
   logic                    reset;
   logic                    tick;
   logic [timer1_width-1:0] timer1_limit;
   logic [timer2_width-1:0] timer2_limit;
   logic [count_width-1:0]  range_count;
   logic [count_width-1:0]  req_count;
   logic                    req_valid;
   logic [cid_width-1:0]    req_cid;
   logic                    cpl_valid;
   logic [status_width-1:0] cpl_status;
   logic                    io_idle;
   logic                    cmd_valid;
   logic [cid_width-1:0]    cmd_cid;
   unmap_event_t            cmd_event;
   logic [wbufid_width-1:0] cmd_wbufid;
   logic [status_width-1:0] cmd_status;
   logic [count_width-1:0]  cmd_reloff;
   logic                    cmd_ack;
   logic                    wbuf_valid;
   logic [wbufid_width-1:0] wbuf_id;
   logic                    wbuf_ack;
   logic                    idfree_valid;
   logic [wbufid_width-1:0] idfree_wbufid;
   logic                    idfree_ack;

   // expected command events and buffer frees
   logic [cid_width-1:0]    exp_cid[$];
   logic [3:0]              exp_ev[$];
   logic [wbufid_width-1:0] exp_wb[$];
   logic [status_width-1:0] exp_st[$];
   logic [count_width-1:0]  exp_off[$];
   int                      exp_batch[$];
   logic [wbufid_width-1:0] exp_free[$];
   logic [15:0]             test_cids[$];

   logic [wbufid_width-1:0] wb_table[16];
   logic [status_width-1:0] st_table[16];
   logic [15:0]             lfsr_state;
   int wb_idx;
   int cpl_idx;
   int cpl_pending;
   int cpl_wait;
   int frees_done;
   int cycle;
   int last_wl_cycle;
   int errors;
   int test_errors;
   int tests_failed;
   logic wbuf_valid_q;
   string cur_test;

   `include "tb_unmap_model.svh"

   unmap_top unmap_top_inst (
      .clk(clk), .reset(reset), .tick(tick),
      .timer1_limit(timer1_limit), .timer2_limit(timer2_limit),
      .range_count(range_count), .req_count(req_count),
      .req_valid(req_valid), .req_cid(req_cid),
      .cpl_valid(cpl_valid), .cpl_status(cpl_status), .io_idle(io_idle),
      .cmd_valid(cmd_valid), .cmd_cid(cmd_cid), .cmd_event(cmd_event),
      .cmd_wbufid(cmd_wbufid), .cmd_status(cmd_status), .cmd_reloff(cmd_reloff),
      .cmd_ack(cmd_ack), .wbuf_valid(wbuf_valid), .wbuf_id(wbuf_id),
      .wbuf_ack(wbuf_ack), .idfree_valid(idfree_valid),
      .idfree_wbufid(idfree_wbufid), .idfree_ack(idfree_ack)
   );

   // galois lfsr, one step per bit taken
   function automatic logic lfsr_bit();
      logic b;
      b = lfsr_state[0];
      lfsr_state = lfsr_state >> 1;
      if (b)
         lfsr_state = lfsr_state ^ 16'hB400;
      return b;
   endfunction

   function automatic logic [15:0] lfsr_bits(input int n);
      logic [15:0] v;
      v = '0;
      for (int i = 0; i < n; i++)
         v = {v[14:0], lfsr_bit()};
      return v;
   endfunction

   function automatic void note_error();
      errors      = errors + 1;
      test_errors = test_errors + 1;
   endfunction

   initial
   begin
      clk = 1'b0;
      forever #2 clk = ~clk;
   end

   // ---------------------------------------------------------
   // monitor and comparison
   // ---------------------------------------------------------
   task automatic compare_event();
      logic [cid_width-1:0]    e_cid;
      logic [3:0]              e_ev;
      logic [wbufid_width-1:0] e_wb;
      logic [status_width-1:0] e_st;
      logic [count_width-1:0]  e_off;
      int                      e_batch;
      if (exp_cid.size() == 0)
      begin
         assert (0) else
         begin
            $display("%s: unexpected command event for cid %h", cur_test, cmd_cid);
            note_error();
         end
         return;
      end
      e_cid   = exp_cid.pop_front();
      e_ev    = exp_ev.pop_front();
      e_wb    = exp_wb.pop_front();
      e_st    = exp_st.pop_front();
      e_off   = exp_off.pop_front();
      e_batch = exp_batch.pop_front();
      assert (cmd_cid == e_cid) else
      begin
         $display("mismatch %s cid expected %h actual %h", cur_test, e_cid, cmd_cid);
         note_error();
      end
      assert (4'(cmd_event) == e_ev) else
      begin
         $display("mismatch %s event expected %0d actual %0d", cur_test, e_ev, cmd_event);
         note_error();
      end
      assert (cmd_wbufid == e_wb) else
      begin
         $display("mismatch %s wbufid expected %0d actual %0d", cur_test, e_wb, cmd_wbufid);
         note_error();
      end
      if (e_ev == 4'(ev_cpl))
      begin
         assert (cmd_status == e_st) else
         begin
            $display("mismatch %s status expected %h actual %h", cur_test, e_st, cmd_status);
            note_error();
         end
         assert (frees_done == e_batch + 1) else
         begin
            $display("%s: completion sent before its buffer was freed", cur_test);
            note_error();
         end
      end
      else
      begin
         assert (cmd_reloff == e_off) else
         begin
            $display("mismatch %s reloff expected %0d actual %0d", cur_test, e_off, cmd_reloff);
            note_error();
         end
      end
      if (cmd_event == ev_write_last)
      begin
         cpl_pending   = cpl_pending + 1;
         last_wl_cycle = cycle;
      end
   endtask

   task automatic compare_free();
      logic [wbufid_width-1:0] e_wb;
      if (exp_free.size() == 0)
      begin
         assert (0) else
         begin
            $display("%s: unexpected buffer free of id %0d", cur_test, idfree_wbufid);
            note_error();
         end
         return;
      end
      e_wb = exp_free.pop_front();
      assert (idfree_wbufid == e_wb) else
      begin
         $display("mismatch %s idfree expected %0d actual %0d", cur_test, e_wb, idfree_wbufid);
         note_error();
      end
      frees_done = frees_done + 1;
   endtask

   always @(posedge clk)
   begin
      cycle = cycle + 1;
      if (!reset)
      begin
         if (cmd_valid && cmd_ack)
            compare_event();
         if (idfree_valid && idfree_ack)
            compare_free();
         if (wbuf_valid && wbuf_ack)
            wb_idx = wb_idx + 1;
         // with the host busy, a new batch must respect the gap after the last one
         if (wbuf_valid && !wbuf_valid_q && !io_idle && last_wl_cycle >= 0)
         begin
            assert (cycle - last_wl_cycle >= int'(timer2_limit) + 1) else
            begin
               $display("%s: batch started %0d cycles after the previous one", cur_test,
                        cycle - last_wl_cycle);
               note_error();
            end
         end
         wbuf_valid_q = wbuf_valid;
      end
   end

   // ack responders and the batch completion, driven on the falling edge
   always @(negedge clk)
   begin
      cmd_ack    = lfsr_bit();
      wbuf_ack   = lfsr_bit();
      idfree_ack = lfsr_bit();
      wbuf_id    = wb_table[wb_idx[3:0]];
      cpl_valid  = 1'b0;
      if (cpl_pending > 0)
      begin
         if (cpl_wait == 3)
         begin
            cpl_valid   = 1'b1;
            cpl_status  = st_table[cpl_idx[3:0]];
            cpl_idx     = cpl_idx + 1;
            cpl_pending = cpl_pending - 1;
            cpl_wait    = 0;
         end
         else
            cpl_wait = cpl_wait + 1;
      end
   end

   initial
   begin
      @(posedge clk);
      while (cycle < cycle_limit)
         @(posedge clk);
      $display("timeout: run went past %0d cycles", cycle_limit);
      $display("TEST FAILED");
      $finish;
   end

   // ---------------------------------------------------------
   // test helpers
   // ---------------------------------------------------------
   task automatic start_test(input string name, input int n);
      cur_test    = name;
      test_errors = 0;
      wb_idx      = 0;
      cpl_idx     = 0;
      frees_done  = 0;
      test_cids.delete();
      for (int i = 0; i < 16; i++)
      begin
         wb_table[i] = wbufid_width'(lfsr_bits(wbufid_width));
         st_table[i] = status_width'(lfsr_bits(status_width));
      end
      for (int i = 0; i < n; i++)
         test_cids.push_back(lfsr_bits(16));
   endtask

   task automatic push_cids(input int from, input int upto);
      for (int i = from; i < upto; i++)
      begin
         @(negedge clk);
         req_valid = 1'b1;
         req_cid   = test_cids[i];
      end
      @(negedge clk);
      req_valid = 1'b0;
   endtask

   // buffer request must show up within a few cycles
   task automatic expect_wbuf(input int max_cycles);
      int n;
      n = 0;
      while (!wbuf_valid && n < max_cycles)
      begin
         @(negedge clk);
         n = n + 1;
      end
      assert (wbuf_valid) else
      begin
         $display("%s: wbuf_valid did not rise within %0d cycles", cur_test, max_cycles);
         note_error();
      end
   endtask

   task automatic end_test();
      while (exp_cid.size() != 0 || exp_free.size() != 0)
         @(negedge clk);
      repeat (5) @(negedge clk);
      if (test_errors != 0)
         tests_failed = tests_failed + 1;
      $display("%s %s, errors %0d", cur_test, (test_errors == 0) ? "ok" : "bad",
               test_errors);
   endtask

   initial
   begin
      lfsr_state    = 16'd35293;
      cycle         = 0;
      last_wl_cycle = -1;
      errors        = 0;
      tests_failed  = 0;
      cpl_pending   = 0;
      cpl_wait      = 0;
      wb_idx        = 0;
      cpl_idx       = 0;
      wbuf_valid_q  = 1'b0;
      cur_test      = "reset";
      for (int i = 0; i < 16; i++)
      begin
         wb_table[i] = '0;
         st_table[i] = '0;
      end
      reset        = 1'b1;
      tick         = 1'b1;
      timer1_limit = timer1_width'(t1_short);
      timer2_limit = timer2_width'(t2_lim);
      range_count  = 8'd3;
      req_count    = 8'd16;
      req_valid    = 1'b0;
      req_cid      = '0;
      cpl_valid    = 1'b0;
      cpl_status   = '0;
      io_idle      = 1'b0;
      cmd_ack      = 1'b0;
      wbuf_ack     = 1'b0;
      wbuf_id      = '0;
      idfree_ack   = 1'b0;
      repeat (3) @(negedge clk);
      reset = 1'b0;

      start_test("single_request", 1);
      build_expected(test_cids, 3);
      push_cids(0, 1);
      end_test();

      start_test("batch_split", 10);
      build_expected(test_cids, 3);
      push_cids(0, 10);
      end_test();

      range_count = 8'd1;
      start_test("completion_fanout", 5);
      build_expected(test_cids, 1);
      push_cids(0, 5);
      end_test();

      // combine delay out of reach, only the queue depth can start a batch
      timer1_limit = timer1_width'(t1_max);
      range_count  = 8'd7;
      req_count    = 8'd4;
      start_test("req_count_override", 4);
      build_expected(test_cids, 7);
      push_cids(0, 3);
      repeat (200)
      begin
         @(negedge clk);
         assert (!wbuf_valid) else
         begin
            $display("%s: wbuf_valid rose with fewer cids than req_count", cur_test);
            note_error();
         end
      end
      push_cids(3, 4);
      expect_wbuf(3);
      end_test();

      timer1_limit = timer1_width'(t1_short);
      timer2_limit = timer2_width'(t2_long);
      req_count    = 8'd16;
      start_test("idle_and_gap", 1);
      build_expected(test_cids, 7);
      io_idle = 1'b1;
      repeat (t1_short + 3) @(negedge clk);
      req_valid = 1'b1;
      req_cid   = test_cids[0];
      @(negedge clk);
      req_valid = 1'b0;
      expect_wbuf(2);
      end_test();
      // two single-cid batches separated by the gap timer
      io_idle     = 1'b0;
      range_count = 8'd0;
      start_test("gap_timer", 2);
      build_expected(test_cids, 0);
      push_cids(0, 2);
      end_test();

      $display("tests %0d, failed %0d, errors %0d", num_tests, tests_failed, errors);
      if (errors == 0)
         $display("TEST PASSED");
      else
         $display("TEST FAILED");
      $finish;
   end

endmodule

// ==== unmap_batch_fsm.sv ====
// ---------------------------------------------------------
// unmap batch state machine
// buffer allocation, write events, buffer free, completions
// ---------------------------------------------------------

`timescale 1ns/1ns

module unmap_batch_fsm
(
   input  logic                                clk,
   input  logic                                reset,
   input  logic                                combine_done,
   input  logic                                gap_done,
   input  logic                                idle_done,
   input  logic                                req_fifo_valid,
   input  logic [unmap_pkg::used_width-1:0]    req_fifo_used,
   input  logic [unmap_pkg::cid_width-1:0]     req_fifo_cid,
   output logic                                req_pop,
   input  logic                                rsp_fifo_valid,
   input  logic [unmap_pkg::cid_width-1:0]     rsp_fifo_cid,
   output logic                                rsp_pop,
   input  logic [unmap_pkg::count_width-1:0]   range_count,
   input  logic [unmap_pkg::count_width-1:0]   req_count,
   output logic                                wbuf_valid,
   input  logic [unmap_pkg::wbufid_width-1:0]  wbuf_id,
   input  logic                                wbuf_ack,
   output logic                                idfree_valid,
   output logic [unmap_pkg::wbufid_width-1:0]  idfree_wbufid,
   input  logic                                idfree_ack,
   input  logic                                cpl_valid,
   input  logic [unmap_pkg::status_width-1:0]  cpl_status,
   output logic                                cmd_valid,
   output logic [unmap_pkg::cid_width-1:0]     cmd_cid,
   output unmap_pkg::unmap_event_t             cmd_event,
   output logic [unmap_pkg::wbufid_width-1:0]  cmd_wbufid,
   output logic [unmap_pkg::status_width-1:0]  cmd_status,
   output logic [unmap_pkg::count_width-1:0]   cmd_reloff,
   input  logic                                cmd_ack,
   output logic                                batch_done
);
   import unmap_pkg::*;

   unmap_state_t            state_q, state_d;
   logic [count_width-1:0]  count_q, count_d;
   logic [wbufid_width-1:0] wbufid_q, wbufid_d;
   logic [cid_width-1:0]    cid_q, cid_d;
   logic [status_width-1:0] status_q, status_d;
   logic                    start;
   logic                    last;

   always_ff @(posedge clk or posedge reset)
   begin
      if (reset)
      begin
         state_q <= idle;
         count_q <= '0;
      end
      else
      begin
         state_q <= state_d;
         count_q <= count_d;
      end
   end

   always_ff @(posedge clk)
   begin
      wbufid_q <= wbufid_d;
      cid_q    <= cid_d;
      status_q <= status_d;
   end

   // timers expired, queue filling up, or host gone quiet
   assign start = (combine_done && gap_done) ||
                  (count_width'(req_fifo_used) >= req_count) ||
                  (req_fifo_valid && idle_done);

   // this cid closes the batch
   assign last = (count_q == range_count) ||
                 (count_q == count_width'(max_ranges)) ||
                 !req_fifo_valid;

   // ---------------------------------------------------------
   // next state and outputs
   // ---------------------------------------------------------
   always_comb
   begin
      state_d       = state_q;
      count_d       = count_q;
      wbufid_d      = wbufid_q;
      cid_d         = cid_q;
      status_d      = status_q;
      req_pop       = 1'b0;
      rsp_pop       = 1'b0;
      wbuf_valid    = 1'b0;
      idfree_valid  = 1'b0;
      idfree_wbufid = wbufid_q;
      cmd_valid     = 1'b0;
      cmd_cid       = cid_q;
      cmd_event     = ev_write;
      cmd_wbufid    = wbufid_q;
      cmd_status    = status_q;
      cmd_reloff    = count_q;
      batch_done    = 1'b0;

      case (state_q)
         idle:
         begin
            if (start)
               state_d = wbuf;
         end
         wbuf:
         begin
            wbuf_valid = 1'b1;
            count_d    = '0;
            if (wbuf_ack)
            begin
               // take the first cid along with the buffer
               wbufid_d = wbuf_id;
               cid_d    = req_fifo_cid;
               req_pop  = 1'b1;
               state_d  = req;
            end
         end
         req:
         begin
            cmd_valid = 1'b1;
            if (last)
               cmd_event = ev_write_last;
            if (cmd_ack)
            begin
               if (last)
               begin
                  batch_done = 1'b1;
                  state_d    = rsp_wait;
               end
               else
                  state_d = req_next;
            end
         end
         req_next:
         begin
            count_d = count_q + 1'b1;
            cid_d   = req_fifo_cid;
            req_pop = 1'b1;
            state_d = req;
         end
         rsp_wait:
         begin
            // one completion covers the whole batch
            if (cpl_valid)
            begin
               status_d = cpl_status;
               cid_d    = rsp_fifo_cid;
               rsp_pop  = 1'b1;
               state_d  = rsp_free;
            end
         end
         rsp_free:
         begin
            idfree_valid = 1'b1;
            if (idfree_ack)
               state_d = rsp_cpl;
         end
         rsp_cpl:
         begin
            cmd_valid = 1'b1;
            cmd_event = ev_cpl;
            if (cmd_ack)
               state_d = rsp_next;
         end
         rsp_next:
         begin
            cid_d = rsp_fifo_cid;
            if (rsp_fifo_valid)
            begin
               rsp_pop = 1'b1;
               state_d = rsp_cpl;
            end
            else
               state_d = idle;
         end
         default:
         begin
            state_d = idle;
         end
      endcase
   end

   // an event waiting for command tracking holds its fields
   a_cmd_hold: assert property (@(posedge clk) disable iff (reset)
      (cmd_valid && !cmd_ack) |=> (cmd_valid && $stable(cmd_cid) &&
         $stable(cmd_wbufid) && $stable(cmd_reloff) && $stable(cmd_status)));

endmodule

// ==== unmap_pkg.sv ====
// ---------------------------------------------------------
// unmap coalescer shared definitions
// widths, fifo depth, batch cap, state and event encodings
// ---------------------------------------------------------

package unmap_pkg;

   // ---------------------------------------------------------
   // command and buffer ids
   // ---------------------------------------------------------

   // command id from command tracking
   localparam int cid_width = 16;

   // write buffer id from the buffer manager
   localparam int wbufid_width = 3;

   // ---------------------------------------------------------
   // fifo sizing
   // ---------------------------------------------------------

   // each cid fifo holds every cid the tracker can have outstanding
   localparam int fifo_depth = 16;

   // occupancy count, one bit wider than the pointers
   localparam int used_width = $clog2(fifo_depth) + 1;

   // ---------------------------------------------------------
   // timers, counts and status
   // ---------------------------------------------------------

   // combine delay and idle timers in microseconds
   localparam int timer1_width = 12;

   // gap between batches in microseconds
   localparam int timer2_width = 20;

   // range count, request count and relative offset
   localparam int count_width = 8;

   // hard limit on ranges per deallocate command
   localparam int max_ranges = 250;

   // completion status passed back per cid
   localparam int status_width = 15;

   // batch state machine
   typedef enum logic [3:0] {
      idle,
      wbuf,
      req,
      req_next,
      rsp_wait,
      rsp_free,
      rsp_cpl,
      rsp_next
   } unmap_state_t;

   // events sent to command tracking
   typedef enum logic [3:0] {
      ev_write      = 4'd0,
      ev_write_last = 4'd1,
      ev_cpl        = 4'd2
   } unmap_event_t;

endpackage

// ==== unmap_timers.sv ====
// ---------------------------------------------------------
// unmap microsecond timers
// combine delay, gap between batches, host idle
// ---------------------------------------------------------

`timescale 1ns/1ns

module unmap_timers
(
   input  logic                                clk,
   input  logic                                reset,
   input  logic                                tick,
   input  logic                                req_fifo_valid,
   input  logic                                io_idle,
   input  logic                                batch_done,
   input  logic [unmap_pkg::timer1_width-1:0]  timer1_limit,
   input  logic [unmap_pkg::timer2_width-1:0]  timer2_limit,
   output logic                                combine_done,
   output logic                                gap_done,
   output logic                                idle_done
);
   import unmap_pkg::*;

   logic [timer1_width-1:0] combine_cnt;
   logic [timer2_width-1:0] gap_cnt;
   logic [timer1_width-1:0] idle_cnt;

   // ---------------------------------------------------------
   // combine delay
   // ---------------------------------------------------------
   // runs while requests wait, so later unmaps join the batch
   always_ff @(posedge clk or posedge reset)
   begin
      if (reset)
      begin
         combine_cnt  <= '0;
         combine_done <= 1'b0;
      end
      else if (batch_done)
      begin
         combine_cnt  <= '0;
         combine_done <= 1'b0;
      end
      else if (req_fifo_valid && !combine_done && tick)
      begin
         combine_cnt <= combine_cnt + 1'b1;
         if (combine_cnt == timer1_limit)
            combine_done <= 1'b1;
      end
   end

   // ---------------------------------------------------------
   // gap after a batch
   // ---------------------------------------------------------
   // keeps deallocates from crowding out reads and writes
   // starts out expired so the first batch is not held back
   always_ff @(posedge clk or posedge reset)
   begin
      if (reset)
      begin
         gap_cnt  <= '0;
         gap_done <= 1'b1;
      end
      else if (batch_done)
      begin
         gap_cnt  <= '0;
         gap_done <= 1'b0;
      end
      else if (!gap_done && tick)
      begin
         gap_cnt <= gap_cnt + 1'b1;
         if (gap_cnt == timer2_limit)
            gap_done <= 1'b1;
      end
   end

   // host idle, any read or write traffic restarts it
   always_ff @(posedge clk or posedge reset)
   begin
      if (reset)
      begin
         idle_cnt  <= '0;
         idle_done <= 1'b0;
      end
      else if (!io_idle)
      begin
         idle_cnt  <= '0;
         idle_done <= 1'b0;
      end
      else if (!idle_done && tick)
      begin
         idle_cnt <= idle_cnt + 1'b1;
         if (idle_cnt == timer1_limit)
            idle_done <= 1'b1;
      end
   end

   a_gap_clear: assert property (@(posedge clk) disable iff (reset)
      $fell(gap_done) |-> $past(batch_done));

endmodule

// ==== unmap_top.sv ====
// ---------------------------------------------------------
// unmap coalescer top
// request and response cid fifos, timers, batch fsm
// ---------------------------------------------------------

`timescale 1ns/1ns

module unmap_top
(
   input  logic                                clk,
   input  logic                                reset,
   input  logic                                tick,
   input  logic [unmap_pkg::timer1_width-1:0]  timer1_limit,
   input  logic [unmap_pkg::timer2_width-1:0]  timer2_limit,
   input  logic [unmap_pkg::count_width-1:0]   range_count,
   input  logic [unmap_pkg::count_width-1:0]   req_count,
   input  logic                                req_valid,
   input  logic [unmap_pkg::cid_width-1:0]     req_cid,
   input  logic                                cpl_valid,
   input  logic [unmap_pkg::status_width-1:0]  cpl_status,
   input  logic                                io_idle,
   output logic                                cmd_valid,
   output logic [unmap_pkg::cid_width-1:0]     cmd_cid,
   output unmap_pkg::unmap_event_t             cmd_event,
   output logic [unmap_pkg::wbufid_width-1:0]  cmd_wbufid,
   output logic [unmap_pkg::status_width-1:0]  cmd_status,
   output logic [unmap_pkg::count_width-1:0]   cmd_reloff,
   input  logic                                cmd_ack,
   output logic                                wbuf_valid,
   input  logic [unmap_pkg::wbufid_width-1:0]  wbuf_id,
   input  logic                                wbuf_ack,
   output logic                                idfree_valid,
   output logic [unmap_pkg::wbufid_width-1:0]  idfree_wbufid,
   input  logic                                idfree_ack
);
   import unmap_pkg::*;

   logic                  req_fifo_valid;
   logic [used_width-1:0] req_fifo_used;
   logic [cid_width-1:0]  req_fifo_cid;
   logic                  req_pop;
   logic                  rsp_fifo_valid;
   logic [cid_width-1:0]  rsp_fifo_cid;
   logic                  rsp_pop;
   logic                  combine_done;
   logic                  gap_done;
   logic                  idle_done;
   logic                  batch_done;

   // no back-pressure, sized for every outstanding cid
   cid_fifo req_fifo_inst (
      .clk   (clk),
      .reset (reset),
      .push  (req_valid),
      .din   (req_cid),
      .pop   (req_pop),
      .valid (req_fifo_valid),
      .dout  (req_fifo_cid),
      .used  (req_fifo_used)
   );

   // cids move here as they are written to the buffer
   cid_fifo rsp_fifo_inst (
      .clk   (clk),
      .reset (reset),
      .push  (req_pop),
      .din   (req_fifo_cid),
      .pop   (rsp_pop),
      .valid (rsp_fifo_valid),
      .dout  (rsp_fifo_cid),
      .used  ()
   );

   unmap_timers unmap_timers_inst (
      .clk            (clk),
      .reset          (reset),
      .tick           (tick),
      .req_fifo_valid (req_fifo_valid),
      .io_idle        (io_idle),
      .batch_done     (batch_done),
      .timer1_limit   (timer1_limit),
      .timer2_limit   (timer2_limit),
      .combine_done   (combine_done),
      .gap_done       (gap_done),
      .idle_done      (idle_done)
   );

   unmap_batch_fsm unmap_batch_fsm_inst (
      .clk            (clk),
      .reset          (reset),
      .combine_done   (combine_done),
      .gap_done       (gap_done),
      .idle_done      (idle_done),
      .req_fifo_valid (req_fifo_valid),
      .req_fifo_used  (req_fifo_used),
      .req_fifo_cid   (req_fifo_cid),
      .req_pop        (req_pop),
      .rsp_fifo_valid (rsp_fifo_valid),
      .rsp_fifo_cid   (rsp_fifo_cid),
      .rsp_pop        (rsp_pop),
      .range_count    (range_count),
      .req_count      (req_count),
      .wbuf_valid     (wbuf_valid),
      .wbuf_id        (wbuf_id),
      .wbuf_ack       (wbuf_ack),
      .idfree_valid   (idfree_valid),
      .idfree_wbufid  (idfree_wbufid),
      .idfree_ack     (idfree_ack),
      .cpl_valid      (cpl_valid),
      .cpl_status     (cpl_status),
      .cmd_valid      (cmd_valid),
      .cmd_cid        (cmd_cid),
      .cmd_event      (cmd_event),
      .cmd_wbufid     (cmd_wbufid),
      .cmd_status     (cmd_status),
      .cmd_reloff     (cmd_reloff),
      .cmd_ack        (cmd_ack),
      .batch_done     (batch_done)
   );

endmodule

// ==== vlog.f ====
+incdir+.
unmap_pkg.sv
cid_fifo.sv
unmap_timers.sv
unmap_batch_fsm.sv
unmap_top.sv
tb_unmap.sv
